//--- snn_cfg_config.svh
/* snn configuration memory sizes */
`ifndef SNN_CFG_CONFIG_SVH
`define SNN_CFG_CONFIG_SVH

// config data word, also every bank word
`define CFG_DATA_W 32

// 16 neurons per bank, 16 axons
`define NRN_ADDR_W 4
`define AXN_ADDR_W 4

// learn-mode bits per packed word
`define LM_WORD_W 4

// potential and rate fields
`define DSIZE 16
`define STDP_WIN_W 8

`define NUM_TABLES 7

// neuron and axon count registers
`define CNT_W 8

`endif

//--- cfg_cmd_pkg.sv
/* configuration opcodes */
`default_nettype none

package cfg_cmd_pkg;

	// table opcodes follow the bank order
	typedef enum logic [3:0]
	{
		OP_STDP_WIN  = 4'd0,
		OP_LRN_RATE  = 4'd1,
		OP_BIAS_MODE = 4'd2,
		OP_NRN_TYPE  = 4'd3,
		OP_MASK_RST  = 4'd4,
		OP_AER       = 4'd5,
		OP_FIX_TH    = 4'd6,
		OP_LRN_MODE  = 4'd7,
		OP_COUNTS    = 4'd8
	} cfg_op_e;

endpackage

`default_nettype wire

//--- param_table_pkg.sv
/* parameter bank index */
`default_nettype none

package param_table_pkg;

	// first three banks feed port A, the rest port B
	typedef enum logic [2:0]
	{
		TBL_STDP_WIN  = 3'd0,
		TBL_LRN_RATE  = 3'd1,
		TBL_BIAS_MODE = 3'd2,
		TBL_NRN_TYPE  = 3'd3,
		TBL_MASK_RST  = 3'd4,
		TBL_AER       = 3'd5,
		TBL_FIX_TH    = 3'd6
	} table_e;

endpackage

`default_nettype wire

//--- cfg_access_ctrl.sv
/* configuration access control */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module cfg_access_ctrl
(
	input  logic                                         clk_i,
	input  logic                                         rst_n_i,
	input  logic                                         cfg_we_i,
	input  cfg_cmd_pkg::cfg_op_e                         cfg_op_i,
	input  logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]           cfg_addr_i,
	input  logic [`CFG_DATA_W-1:0]                       cfg_data_i,
	input  logic                                         rd_a_i,
	input  logic [`NRN_ADDR_W-1:0]                       rd_a_addr_i,
	input  logic                                         rd_b_i,
	input  logic [`NRN_ADDR_W-1:0]                       rd_b_addr_i,
	output logic [`NUM_TABLES-1:0]                       bank_we_o,
	output logic [`NUM_TABLES-1:0]                       bank_re_o,
	output logic [`NUM_TABLES-1:0][`NRN_ADDR_W-1:0]      bank_addr_o,
	output logic [`CFG_DATA_W-1:0]                       bank_wdata_o,
	output logic                                         lm_we_o,
	output logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]           lm_waddr_o,
	output logic                                         lm_wbit_o,
	output logic [`CNT_W-1:0]                            num_neurons_o,
	output logic [`CNT_W-1:0]                            num_axons_o
);

	logic [`NRN_ADDR_W-1:0] wr_nrn;

	// neuron sits in the upper address bits
	assign wr_nrn = cfg_addr_i[`NRN_ADDR_W+`AXN_ADDR_W-1:`AXN_ADDR_W];

	always_comb
	begin
		for (int i = 0; i < `NUM_TABLES; i++)
		begin
			bank_we_o[i] = cfg_we_i && (cfg_op_i == cfg_cmd_pkg::cfg_op_e'(i));
			// write wins, so a bank being written skips its read
			if (i <= int'(param_table_pkg::TBL_BIAS_MODE))
			begin
				bank_re_o[i]   = rd_a_i && !bank_we_o[i];
				bank_addr_o[i] = bank_we_o[i] ? wr_nrn : rd_a_addr_i;
			end
			else
			begin
				bank_re_o[i]   = rd_b_i && !bank_we_o[i];
				bank_addr_o[i] = bank_we_o[i] ? wr_nrn : rd_b_addr_i;
			end
		end
	end

	assign bank_wdata_o = cfg_data_i;

	// learn-mode write keeps the full neuron-axon address
	assign lm_we_o    = cfg_we_i && (cfg_op_i == cfg_cmd_pkg::OP_LRN_MODE);
	assign lm_waddr_o = cfg_addr_i;
	assign lm_wbit_o  = cfg_data_i[0];

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (rst_n_i == 1'b0)
		begin
			num_neurons_o <= '0;
			num_axons_o   <= '0;
		end
		else if (cfg_we_i && (cfg_op_i == cfg_cmd_pkg::OP_COUNTS))
		begin
			// neuron count above axon count
			num_neurons_o <= cfg_data_i[2*`CNT_W-1:`CNT_W];
			num_axons_o   <= cfg_data_i[`CNT_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- param_bank.sv
/* parameter table bank */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module param_bank
(
	input  logic                    clk_i,
	input  logic                    rst_n_i,
	input  logic                    we_i,
	input  logic                    re_i,
	input  logic [`NRN_ADDR_W-1:0]  addr_i,
	input  logic [`CFG_DATA_W-1:0]  wdata_i,
	output logic [`CFG_DATA_W-1:0]  rdata_o
);

	localparam int DEPTH = 1 << `NRN_ADDR_W;

	logic [`CFG_DATA_W-1:0] mem [DEPTH];

	always_ff @(posedge clk_i)
	begin
		if (we_i)
			mem[addr_i] <= wdata_i;
	end

	// read word holds until the next read
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (rst_n_i == 1'b0)
		begin
			rdata_o <= '0;
		end
		else if (re_i)
		begin
			rdata_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire

//--- param_read_port.sv
/* port A and port B field registers */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module param_read_port
(
	input  logic                                     clk_i,
	input  logic                                     rst_n_i,
	input  logic [`NUM_TABLES-1:0]                   bank_re_i,
	input  logic [`NUM_TABLES-1:0][`CFG_DATA_W-1:0]  bank_rdata_i,
	output logic [`STDP_WIN_W-1:0]                   ltp_win_o,
	output logic [`STDP_WIN_W-1:0]                   ltd_win_o,
	output logic [`DSIZE-1:0]                        ltp_rate_o,
	output logic [`DSIZE-1:0]                        ltd_rate_o,
	output logic                                     bias_lrn_mode_o,
	output logic                                     valid_a_o,
	output logic                                     nrn_type_o,
	output logic                                     rand_th_o,
	output logic [`DSIZE-1:0]                        th_mask_o,
	output logic [`DSIZE-1:0]                        rst_pot_o,
	output logic [`CFG_DATA_W-1:0]                   spike_aer_o,
	output logic [`DSIZE-1:0]                        fix_th_o,
	output logic                                     valid_b_o
);

	logic grp_a_re;
	logic grp_b_re;
	logic grp_a_q;
	logic grp_b_q;
	logic [`CFG_DATA_W-1:0] win_w;
	logic [`CFG_DATA_W-1:0] rate_w;
	logic [`CFG_DATA_W-1:0] bias_w;
	logic [`CFG_DATA_W-1:0] type_w;
	logic [`CFG_DATA_W-1:0] mask_w;
	logic [`CFG_DATA_W-1:0] aer_w;
	logic [`CFG_DATA_W-1:0] fix_w;

	// only one bank is written per cycle, so the OR still tracks the strobe
	assign grp_a_re = bank_re_i[param_table_pkg::TBL_STDP_WIN]
		| bank_re_i[param_table_pkg::TBL_LRN_RATE]
		| bank_re_i[param_table_pkg::TBL_BIAS_MODE];
	assign grp_b_re = bank_re_i[param_table_pkg::TBL_NRN_TYPE]
		| bank_re_i[param_table_pkg::TBL_MASK_RST]
		| bank_re_i[param_table_pkg::TBL_AER]
		| bank_re_i[param_table_pkg::TBL_FIX_TH];

	assign win_w  = bank_rdata_i[param_table_pkg::TBL_STDP_WIN];
	assign rate_w = bank_rdata_i[param_table_pkg::TBL_LRN_RATE];
	assign bias_w = bank_rdata_i[param_table_pkg::TBL_BIAS_MODE];
	assign type_w = bank_rdata_i[param_table_pkg::TBL_NRN_TYPE];
	assign mask_w = bank_rdata_i[param_table_pkg::TBL_MASK_RST];
	assign aer_w  = bank_rdata_i[param_table_pkg::TBL_AER];
	assign fix_w  = bank_rdata_i[param_table_pkg::TBL_FIX_TH];

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (rst_n_i == 1'b0)
		begin
			grp_a_q   <= 1'b0;
			grp_b_q   <= 1'b0;
			valid_a_o <= 1'b0;
			valid_b_o <= 1'b0;
		end
		else
		begin
			// bank word lands one edge after the strobe
			grp_a_q   <= grp_a_re;
			grp_b_q   <= grp_b_re;
			valid_a_o <= grp_a_q;
			valid_b_o <= grp_b_q;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (rst_n_i == 1'b0)
		begin
			ltp_win_o       <= '0;
			ltd_win_o       <= '0;
			ltp_rate_o      <= '0;
			ltd_rate_o      <= '0;
			bias_lrn_mode_o <= 1'b0;
			nrn_type_o      <= 1'b0;
			rand_th_o       <= 1'b0;
			th_mask_o       <= '0;
			rst_pot_o       <= '0;
			spike_aer_o     <= '0;
			fix_th_o        <= '0;
		end
		else
		begin
			if (grp_a_q)
			begin
				ltp_win_o       <= win_w[2*`STDP_WIN_W-1:`STDP_WIN_W];
				ltd_win_o       <= win_w[`STDP_WIN_W-1:0];
				ltp_rate_o      <= rate_w[2*`DSIZE-1:`DSIZE];
				ltd_rate_o      <= rate_w[`DSIZE-1:0];
				bias_lrn_mode_o <= bias_w[0];
			end
			if (grp_b_q)
			begin
				// type in bit 1, random threshold flag in bit 0
				nrn_type_o  <= type_w[1];
				rand_th_o   <= type_w[0];
				th_mask_o   <= mask_w[2*`DSIZE-1:`DSIZE];
				rst_pot_o   <= mask_w[`DSIZE-1:0];
				spike_aer_o <= aer_w;
				fix_th_o    <= fix_w[`DSIZE-1:0];
			end
		end
	end

endmodule

`default_nettype wire

//--- lrn_mode_mem.sv
/* packed learn-mode memory */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module lrn_mode_mem
(
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                we_i,
	input  logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]  waddr_i,
	input  logic                                wbit_i,
	input  logic                                re_i,
	input  logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]  raddr_i,
	output logic                                lrn_mode_o,
	output logic                                valid_o
);

	localparam int NUM_AXONS = 1 << `AXN_ADDR_W;
	localparam int WORDS_PER_NRN = NUM_AXONS / `LM_WORD_W;
	localparam int BIT_W = $clog2(`LM_WORD_W);
	localparam int LM_ADDR_W = `NRN_ADDR_W + `AXN_ADDR_W - BIT_W;
	localparam int LM_DEPTH = 1 << LM_ADDR_W;

	logic [`LM_WORD_W-1:0] mem [LM_DEPTH];
	logic [LM_ADDR_W-1:0]  waddr_word;
	logic [LM_ADDR_W-1:0]  raddr_word;
	logic [BIT_W-1:0]      wbit_sel;
	logic [BIT_W-1:0]      rbit_sel;
	logic [`LM_WORD_W-1:0] wmask;
	logic [`LM_WORD_W-1:0] rd_word_q;
	logic [BIT_W-1:0]      rd_bit_q;

	// neuron * (axons / word) + axon / word
	function automatic logic [LM_ADDR_W-1:0] word_addr(
		input logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0] a);
		logic [`NRN_ADDR_W-1:0] nrn;
		logic [`AXN_ADDR_W-1:0] axn;
		nrn = a[`NRN_ADDR_W+`AXN_ADDR_W-1:`AXN_ADDR_W];
		axn = a[`AXN_ADDR_W-1:0];
		return LM_ADDR_W'(nrn * WORDS_PER_NRN + axn / `LM_WORD_W);
	endfunction

	function automatic logic [BIT_W-1:0] bit_index(
		input logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0] a);
		return BIT_W'(a[`AXN_ADDR_W-1:0] % `LM_WORD_W);
	endfunction

	assign waddr_word = word_addr(waddr_i);
	assign wbit_sel   = bit_index(waddr_i);
	assign raddr_word = word_addr(raddr_i);
	assign rbit_sel   = bit_index(raddr_i);
	assign wmask      = `LM_WORD_W'(1) << wbit_sel;

	// masked write leaves the neighbouring bits alone
	always_ff @(posedge clk_i)
	begin
		if (we_i)
		begin
			for (int b = 0; b < `LM_WORD_W; b++)
			begin
				if (wmask[b])
					mem[waddr_word][b] <= wbit_i;
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (rst_n_i == 1'b0)
		begin
			rd_word_q <= '0;
			rd_bit_q  <= '0;
			valid_o   <= 1'b0;
		end
		else
		begin
			valid_o <= re_i;
			if (re_i)
			begin
				rd_word_q <= mem[raddr_word];
				rd_bit_q  <= rbit_sel;
			end
		end
	end

	assign lrn_mode_o = rd_word_q[rd_bit_q];

endmodule

`default_nettype wire

//--- snn_config_mem.sv
/* snn core configuration memory */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module snn_config_mem
(
	input  logic                                clk_i,
	input  logic                                rst_n_i,
	input  logic                                cfg_we_i,
	input  cfg_cmd_pkg::cfg_op_e                cfg_op_i,
	input  logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]  cfg_addr_i,
	input  logic [`CFG_DATA_W-1:0]              cfg_data_i,
	input  logic                                rd_a_i,
	input  logic [`NRN_ADDR_W-1:0]              rd_a_addr_i,
	input  logic                                rd_b_i,
	input  logic [`NRN_ADDR_W-1:0]              rd_b_addr_i,
	input  logic                                rd_c_i,
	input  logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]  rd_c_addr_i,
	output logic [`STDP_WIN_W-1:0]              ltp_win_o,
	output logic [`STDP_WIN_W-1:0]              ltd_win_o,
	output logic [`DSIZE-1:0]                   ltp_rate_o,
	output logic [`DSIZE-1:0]                   ltd_rate_o,
	output logic                                bias_lrn_mode_o,
	output logic                                valid_a_o,
	output logic                                nrn_type_o,
	output logic                                rand_th_o,
	output logic [`DSIZE-1:0]                   th_mask_o,
	output logic [`DSIZE-1:0]                   rst_pot_o,
	output logic [`CFG_DATA_W-1:0]              spike_aer_o,
	output logic [`DSIZE-1:0]                   fix_th_o,
	output logic                                valid_b_o,
	output logic                                lrn_mode_o,
	output logic                                valid_c_o,
	output logic [`CNT_W-1:0]                   num_neurons_o,
	output logic [`CNT_W-1:0]                   num_axons_o
);

	logic [`NUM_TABLES-1:0]                   bank_we;
	logic [`NUM_TABLES-1:0]                   bank_re;
	logic [`NUM_TABLES-1:0][`NRN_ADDR_W-1:0]  bank_addr;
	logic [`CFG_DATA_W-1:0]                   bank_wdata;
	logic [`NUM_TABLES-1:0][`CFG_DATA_W-1:0]  bank_rdata;
	logic                                     lm_we;
	logic [`NRN_ADDR_W+`AXN_ADDR_W-1:0]       lm_waddr;
	logic                                     lm_wbit;

	cfg_access_ctrl i_cfg_access_ctrl
	(
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.cfg_we_i      (cfg_we_i),
		.cfg_op_i      (cfg_op_i),
		.cfg_addr_i    (cfg_addr_i),
		.cfg_data_i    (cfg_data_i),
		.rd_a_i        (rd_a_i),
		.rd_a_addr_i   (rd_a_addr_i),
		.rd_b_i        (rd_b_i),
		.rd_b_addr_i   (rd_b_addr_i),
		.bank_we_o     (bank_we),
		.bank_re_o     (bank_re),
		.bank_addr_o   (bank_addr),
		.bank_wdata_o  (bank_wdata),
		.lm_we_o       (lm_we),
		.lm_waddr_o    (lm_waddr),
		.lm_wbit_o     (lm_wbit),
		.num_neurons_o (num_neurons_o),
		.num_axons_o   (num_axons_o)
	);

	// one bank per table, indexed by param_table_pkg::table_e
	for (genvar t = 0; t < `NUM_TABLES; t++)
	begin : g_bank
		param_bank i_param_bank
		(
			.clk_i   (clk_i),
			.rst_n_i (rst_n_i),
			.we_i    (bank_we[t]),
			.re_i    (bank_re[t]),
			.addr_i  (bank_addr[t]),
			.wdata_i (bank_wdata),
			.rdata_o (bank_rdata[t])
		);
	end

	param_read_port i_param_read_port
	(
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.bank_re_i       (bank_re),
		.bank_rdata_i    (bank_rdata),
		.ltp_win_o       (ltp_win_o),
		.ltd_win_o       (ltd_win_o),
		.ltp_rate_o      (ltp_rate_o),
		.ltd_rate_o      (ltd_rate_o),
		.bias_lrn_mode_o (bias_lrn_mode_o),
		.valid_a_o       (valid_a_o),
		.nrn_type_o      (nrn_type_o),
		.rand_th_o       (rand_th_o),
		.th_mask_o       (th_mask_o),
		.rst_pot_o       (rst_pot_o),
		.spike_aer_o     (spike_aer_o),
		.fix_th_o        (fix_th_o),
		.valid_b_o       (valid_b_o)
	);

	lrn_mode_mem i_lrn_mode_mem
	(
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.we_i       (lm_we),
		.waddr_i    (lm_waddr),
		.wbit_i     (lm_wbit),
		.re_i       (rd_c_i),
		.raddr_i    (rd_c_addr_i),
		.lrn_mode_o (lrn_mode_o),
		.valid_o    (valid_c_o)
	);

endmodule

`default_nettype wire

//--- snn_config_mem_sva.sv
/* configuration memory assertions */
`timescale 1ns/100ps
`default_nettype none

module snn_config_mem_sva
(
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  logic  rd_a_i,
	input  logic  rd_b_i,
	input  logic  rd_c_i,
	input  logic  valid_a_i,
	input  logic  valid_b_i,
	input  logic  valid_c_i
);

	// ports A and B go through the bank register and the field register
	assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_a_i |-> ##2 valid_a_i)
		else $error("valid_a_o missing two cycles after rd_a_i");
	assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_a_i |-> $past(rd_a_i, 2))
		else $error("valid_a_o high without rd_a_i two cycles before");
	assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_b_i |-> ##2 valid_b_i)
		else $error("valid_b_o missing two cycles after rd_b_i");
	assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_b_i |-> $past(rd_b_i, 2))
		else $error("valid_b_o high without rd_b_i two cycles before");

	// learn-mode read is a single register stage
	assert property (@(posedge clk_i) disable iff (!rst_n_i) rd_c_i |=> valid_c_i)
		else $error("valid_c_o missing one cycle after rd_c_i");
	assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_c_i |-> $past(rd_c_i))
		else $error("valid_c_o high without rd_c_i one cycle before");

	assert property (@(posedge clk_i) !rst_n_i |-> !valid_a_i && !valid_b_i && !valid_c_i)
		else $error("valid output high while reset is active");

endmodule

bind snn_config_mem snn_config_mem_sva i_snn_config_mem_sva
(
	.clk_i     (clk_i),
	.rst_n_i   (rst_n_i),
	.rd_a_i    (rd_a_i),
	.rd_b_i    (rd_b_i),
	.rd_c_i    (rd_c_i),
	.valid_a_i (valid_a_o),
	.valid_b_i (valid_b_o),
	.valid_c_i (valid_c_o)
);

`default_nettype wire

//--- tb_snn_config_mem.sv
/* configuration memory testbench */
`timescale 1ns/100ps
`include "snn_cfg_config.svh"
`default_nettype none

module tb_snn_config_mem;

	localparam int NRN_W = `NRN_ADDR_W;
	localparam int AXN_W = `AXN_ADDR_W;
	localparam int CNT_W = `CNT_W;
	localparam int N_NRN = 1 << NRN_W;
	localparam int N_AXN = 1 << AXN_W;
	// table fill and overwrites, A/B reads, back-to-back reads,
	// learn-mode writes and reads, count write, same-cycle steps
	localparam int N_OPS = N_NRN * `NUM_TABLES + 8 + 2 * N_NRN + 2 * 8
		+ 4 * N_AXN + 1 + 2 * 3;
	localparam int TIMEOUT_NS = N_OPS * 20 * 10 + 2000;

	typedef struct packed
	{
		logic                        chk;
		logic [3:0][`CFG_DATA_W-1:0] w;
	} exp_entry_t;

	logic                            clk_i;
	logic                            rst_n_i;
	logic                            cfg_we_i;
	cfg_cmd_pkg::cfg_op_e            cfg_op_i;
	logic [NRN_W+AXN_W-1:0]          cfg_addr_i;
	logic [`CFG_DATA_W-1:0]          cfg_data_i;
	logic                            rd_a_i;
	logic [NRN_W-1:0]                rd_a_addr_i;
	logic                            rd_b_i;
	logic [NRN_W-1:0]                rd_b_addr_i;
	logic                            rd_c_i;
	logic [NRN_W+AXN_W-1:0]          rd_c_addr_i;
	logic [`STDP_WIN_W-1:0]          ltp_win_o;
	logic [`STDP_WIN_W-1:0]          ltd_win_o;
	logic [`DSIZE-1:0]               ltp_rate_o;
	logic [`DSIZE-1:0]               ltd_rate_o;
	logic                            bias_lrn_mode_o;
	logic                            valid_a_o;
	logic                            nrn_type_o;
	logic                            rand_th_o;
	logic [`DSIZE-1:0]               th_mask_o;
	logic [`DSIZE-1:0]               rst_pot_o;
	logic [`CFG_DATA_W-1:0]          spike_aer_o;
	logic [`DSIZE-1:0]               fix_th_o;
	logic                            valid_b_o;
	logic                            lrn_mode_o;
	logic                            valid_c_o;
	logic [CNT_W-1:0]                num_neurons_o;
	logic [CNT_W-1:0]                num_axons_o;

	// reference model of every write
	logic [`CFG_DATA_W-1:0] model [int];
	bit                     lm_model [int];
	exp_entry_t             exp_a [$];
	exp_entry_t             exp_b [$];
	bit                     exp_c [$];
	int                     order [64];
	int                     seq_val = 0;
	int                     seq_proto = 0;
	int                     mon_val = 0;
	int                     mon_proto = 0;

	snn_config_mem i_snn_config_mem (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic int key_of(input int tbl, input int nrn);
		return tbl * N_NRN + nrn;
	endfunction

	// 1 on mismatch
	function automatic int compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		bit ok;
		ok = (act === exp);
		assert (ok)
		else
			$display("[FAIL] t=%0d ns %s expected %h actual %h", $time, name, exp, act);
		return ok ? 0 : 1;
	endfunction

	function automatic int check_port_a(input exp_entry_t e);
		return compare_value("ltp_win_o", 32'(e.w[0][2*`STDP_WIN_W-1:`STDP_WIN_W]),
				32'(ltp_win_o))
			+ compare_value("ltd_win_o", 32'(e.w[0][`STDP_WIN_W-1:0]), 32'(ltd_win_o))
			+ compare_value("ltp_rate_o", 32'(e.w[1][2*`DSIZE-1:`DSIZE]), 32'(ltp_rate_o))
			+ compare_value("ltd_rate_o", 32'(e.w[1][`DSIZE-1:0]), 32'(ltd_rate_o))
			+ compare_value("bias_lrn_mode_o", 32'(e.w[2][0]), 32'(bias_lrn_mode_o));
	endfunction

	function automatic int check_port_b(input exp_entry_t e);
		return compare_value("nrn_type_o", 32'(e.w[0][1]), 32'(nrn_type_o))
			+ compare_value("rand_th_o", 32'(e.w[0][0]), 32'(rand_th_o))
			+ compare_value("th_mask_o", 32'(e.w[1][2*`DSIZE-1:`DSIZE]), 32'(th_mask_o))
			+ compare_value("rst_pot_o", 32'(e.w[1][`DSIZE-1:0]), 32'(rst_pot_o))
			+ compare_value("spike_aer_o", 32'(e.w[2]), 32'(spike_aer_o))
			+ compare_value("fix_th_o", 32'(e.w[3][`DSIZE-1:0]), 32'(fix_th_o));
	endfunction

	// strobes last one cycle
	task automatic next_cycle;
		@(posedge clk_i);
		#1;
		cfg_we_i = 1'b0;
		rd_a_i   = 1'b0;
		rd_b_i   = 1'b0;
		rd_c_i   = 1'b0;
	endtask

	task automatic drive_table_write(input int tbl, input int nrn, input logic [31:0] data);
		cfg_we_i   = 1'b1;
		cfg_op_i   = cfg_cmd_pkg::cfg_op_e'(4'(tbl));
		cfg_addr_i = {NRN_W'(nrn), AXN_W'(0)};
		cfg_data_i = data;
		model[key_of(tbl, nrn)] = data;
	endtask

	task automatic drive_lm_write(input int nrn, input int axn);
		logic [31:0] data;
		data       = $urandom();
		cfg_we_i   = 1'b1;
		cfg_op_i   = cfg_cmd_pkg::OP_LRN_MODE;
		cfg_addr_i = {NRN_W'(nrn), AXN_W'(axn)};
		cfg_data_i = data;
		lm_model[nrn * N_AXN + axn] = data[0];
	endtask

	task automatic issue_read_a(input int nrn, input bit chk);
		exp_entry_t e;
		e.chk  = chk;
		e.w[0] = model[key_of(int'(param_table_pkg::TBL_STDP_WIN), nrn)];
		e.w[1] = model[key_of(int'(param_table_pkg::TBL_LRN_RATE), nrn)];
		e.w[2] = model[key_of(int'(param_table_pkg::TBL_BIAS_MODE), nrn)];
		e.w[3] = '0;
		exp_a.push_back(e);
		rd_a_i      = 1'b1;
		rd_a_addr_i = NRN_W'(nrn);
	endtask

	task automatic issue_read_b(input int nrn, input bit chk);
		exp_entry_t e;
		e.chk  = chk;
		e.w[0] = model[key_of(int'(param_table_pkg::TBL_NRN_TYPE), nrn)];
		e.w[1] = model[key_of(int'(param_table_pkg::TBL_MASK_RST), nrn)];
		e.w[2] = model[key_of(int'(param_table_pkg::TBL_AER), nrn)];
		e.w[3] = model[key_of(int'(param_table_pkg::TBL_FIX_TH), nrn)];
		exp_b.push_back(e);
		rd_b_i      = 1'b1;
		rd_b_addr_i = NRN_W'(nrn);
	endtask

	task automatic issue_read_c(input int nrn, input int axn);
		exp_c.push_back(lm_model[nrn * N_AXN + axn]);
		rd_c_i      = 1'b1;
		rd_c_addr_i = {NRN_W'(nrn), AXN_W'(axn)};
	endtask

	task automatic shuffle_order(input int n);
		int j;
		int tmp;
		for (int i = 0; i < n; i++)
			order[i] = i;
		for (int i = n - 1; i > 0; i--)
		begin
			j        = int'($urandom_range(i, 0));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	task automatic drain_all;
		int n;
		n = 0;
		while ((exp_a.size() + exp_b.size() + exp_c.size() != 0) && n < 8)
		begin
			next_cycle;
			n++;
		end
		if (exp_a.size() + exp_b.size() + exp_c.size() != 0)
		begin
			$display("reads still outstanding with no valid pulse at %0d ns", $time);
			seq_proto++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_i)
	begin
		exp_entry_t ea;
		exp_entry_t eb;
		bit ec;
		if (valid_a_o && exp_a.size() == 0)
		begin
			$display("valid_a_o pulsed with no port A read outstanding at %0d ns", $time);
			mon_proto++;
		end
		else if (valid_a_o)
		begin
			ea = exp_a.pop_front();
			if (ea.chk)
				mon_val += check_port_a(ea);
		end
		if (valid_b_o && exp_b.size() == 0)
		begin
			$display("valid_b_o pulsed with no port B read outstanding at %0d ns", $time);
			mon_proto++;
		end
		else if (valid_b_o)
		begin
			eb = exp_b.pop_front();
			if (eb.chk)
				mon_val += check_port_b(eb);
		end
		if (valid_c_o && exp_c.size() == 0)
		begin
			$display("valid_c_o pulsed with no port C read outstanding at %0d ns", $time);
			mon_proto++;
		end
		else if (valid_c_o)
		begin
			ec = exp_c.pop_front();
			mon_val += compare_value("lrn_mode_o", 32'(ec), 32'(lrn_mode_o));
		end
	end

	initial
	begin
		int t;
		int n;
		int n0;
		int n1;
		logic [CNT_W-1:0] cnt_n;
		logic [CNT_W-1:0] cnt_a;
		void'($urandom(81));
		rst_n_i     = 1'b0;
		cfg_we_i    = 1'b0;
		cfg_op_i    = cfg_cmd_pkg::OP_STDP_WIN;
		cfg_addr_i  = '0;
		cfg_data_i  = '0;
		rd_a_i      = 1'b0;
		rd_a_addr_i = '0;
		rd_b_i      = 1'b0;
		rd_b_addr_i = '0;
		rd_c_i      = 1'b0;
		rd_c_addr_i = '0;
		repeat (3) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;

		seq_val += compare_value("valid_a_o", 32'(0), 32'(valid_a_o));
		seq_val += compare_value("valid_b_o", 32'(0), 32'(valid_b_o));
		seq_val += compare_value("valid_c_o", 32'(0), 32'(valid_c_o));
		seq_val += compare_value("num_neurons_o", 32'(0), 32'(num_neurons_o));
		seq_val += compare_value("num_axons_o", 32'(0), 32'(num_axons_o));

		// fill every table, neurons in random order, then overwrite a few
		shuffle_order(N_NRN);
		for (int i = 0; i < N_NRN; i++)
		begin
			for (int tbl = 0; tbl < `NUM_TABLES; tbl++)
			begin
				drive_table_write(tbl, order[i], $urandom());
				next_cycle;
			end
		end
		repeat (8)
		begin
			t = int'($urandom_range(`NUM_TABLES - 1, 0));
			n = int'($urandom_range(N_NRN - 1, 0));
			drive_table_write(t, n, $urandom());
			next_cycle;
		end

		shuffle_order(N_NRN);
		for (int i = 0; i < N_NRN; i++)
		begin
			issue_read_a(order[i], 1'b1);
			issue_read_b(order[N_NRN - 1 - i], 1'b1);
			repeat (3) next_cycle;
		end
		drain_all;

		// back-to-back strobes keep two reads in flight
		for (int i = 0; i < 8; i++)
		begin
			issue_read_a(int'($urandom_range(N_NRN - 1, 0)), 1'b1);
			issue_read_b(int'($urandom_range(N_NRN - 1, 0)), 1'b1);
			next_cycle;
		end
		drain_all;

		// all axons of two neurons, read back in shuffled order
		n0 = int'($urandom_range(N_NRN - 1, 0));
		n1 = (n0 + 1 + int'($urandom_range(N_NRN - 2, 0))) % N_NRN;
		for (int a = 0; a < N_AXN; a++)
		begin
			drive_lm_write(n0, a);
			next_cycle;
			drive_lm_write(n1, a);
			next_cycle;
		end
		shuffle_order(N_AXN);
		for (int i = 0; i < N_AXN; i++)
		begin
			issue_read_c(n0, order[i]);
			next_cycle;
		end
		shuffle_order(N_AXN);
		for (int i = 0; i < N_AXN; i++)
		begin
			issue_read_c(n1, order[i]);
			next_cycle;
		end
		drain_all;

		cnt_n      = CNT_W'($urandom());
		cnt_a      = CNT_W'($urandom());
		cfg_we_i   = 1'b1;
		cfg_op_i   = cfg_cmd_pkg::OP_COUNTS;
		cfg_addr_i = '0;
		cfg_data_i = $urandom();
		cfg_data_i[2*CNT_W-1:0] = {cnt_n, cnt_a};
		next_cycle;
		seq_val += compare_value("num_neurons_o", 32'(cnt_n), 32'(num_neurons_o));
		seq_val += compare_value("num_axons_o", 32'(cnt_a), 32'(num_axons_o));

		// same-cycle write and read on one bank, once per port
		for (int g = 0; g < 2; g++)
		begin
			n = int'($urandom_range(N_NRN - 1, 0));
			if (g == 0)
			begin
				t = int'($urandom_range(int'(param_table_pkg::TBL_BIAS_MODE), 0));
				issue_read_a(n, 1'b0);
			end
			else
			begin
				t = int'($urandom_range(`NUM_TABLES - 1,
					int'(param_table_pkg::TBL_NRN_TYPE)));
				issue_read_b(n, 1'b0);
			end
			drive_table_write(t, n, $urandom());
			repeat (2) next_cycle;
			if (g == 0)
				issue_read_a(n, 1'b1);
			else
				issue_read_b(n, 1'b1);
			next_cycle;
			drain_all;
		end

		$display("errors: value %0d, protocol %0d", seq_val + mon_val, seq_proto + mon_proto);
		if (seq_val + mon_val + seq_proto + mon_proto == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
cfg_cmd_pkg.sv
param_table_pkg.sv
cfg_access_ctrl.sv
param_bank.sv
param_read_port.sv
lrn_mode_mem.sv
snn_config_mem.sv
snn_config_mem_sva.sv
tb_snn_config_mem.sv

//--- Makefile
# Verilator build for the configuration memory testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_snn_config_mem
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass message
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
